/* bench/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

    localparam int feed_limit  = 50;
    localparam int drain_limit = 200;
    localparam int halt_limit  = 10;
    localparam int table_size  = 32;
    localparam int exp_size    = 128;
    localparam int dep_first   = 10;
    localparam int dep_last    = 14;

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic        instr_valid;
    logic        instr_ready;
    logic        wb_valid;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic        halted;

    // Directed program. Each word carries the idle cycles placed before it.
    logic [15:0] prog_word [table_size];
    int          prog_gap  [table_size];
    int          prog_len;

    // Writebacks of the directed program in order, as worked out by hand.
    logic [2:0]  wb_tab_reg [table_size];
    logic [15:0] wb_tab_val [table_size];
    int          wb_tab_len;

    // All writebacks still to come with the directed ones first.
    logic [2:0]  exp_reg [exp_size];
    logic [15:0] exp_val [exp_size];
    int          exp_wr;
    int          exp_rd = 0;

    logic [15:0] model_regs [8];
    logic [31:0] lcg_state;

    int wb_count = 0;
    int wb_value_errors = 0;
    int wb_other_errors = 0;
    int check_value_errors;
    int check_other_errors;
    int timeouts;

    core_top #(.dmem_depth(64)) DUT (
        .clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid),
        .instr_ready(instr_ready), .wb_valid(wb_valid), .wb_reg(wb_reg),
        .wb_data(wb_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] sext5(logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic logic [15:0] sext8(logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    // Register format results as the function codes define them.
    function automatic logic [15:0] ref_result(logic [1:0] fn, logic [15:0] a, logic [15:0] b);
        logic [15:0] res;
        case (fn)
            cpu_pkg::fn_add:  res = a + b;
            cpu_pkg::fn_sub:  res = a - b;
            cpu_pkg::fn_xor:  res = a ^ b;
            cpu_pkg::fn_andn: res = a & ~b;
            default:          res = '0;
        endcase
        return res;
    endfunction

    function automatic logic [15:0] enc_reg(logic [2:0] rs, logic [2:0] rt, logic [2:0] rd,
                                            logic [1:0] fn);
        return {cpu_pkg::op_alu, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] enc_imm(logic [4:0] op, logic [2:0] rs, logic [2:0] rd,
                                            logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] enc_lbi(logic [2:0] rd, logic [7:0] imm);
        return {cpu_pkg::op_lbi, rd, imm};
    endfunction

    task add_prog(input logic [15:0] word, input int gap);
        prog_word[prog_len] = word;
        prog_gap[prog_len]  = gap;
        prog_len++;
    endtask

    task add_wb(input logic [2:0] r, input logic [15:0] v);
        wb_tab_reg[wb_tab_len] = r;
        wb_tab_val[wb_tab_len] = v;
        wb_tab_len++;
    endtask

    task expect_wb(input logic [2:0] r, input logic [15:0] v);
        exp_reg[exp_wr] = r;
        exp_val[exp_wr] = v;
        exp_wr++;
        model_regs[r] = v;
    endtask

    task load_tables();
        prog_len   = 0;
        wb_tab_len = 0;
        add_prog(enc_lbi(3'd1, 8'h35), 0);
        add_wb(3'd1, 16'h0035);
        add_prog(enc_lbi(3'd2, 8'h81), 1);
        add_wb(3'd2, 16'hff81);
        add_prog(enc_lbi(3'd3, 8'h7f), 0);
        add_wb(3'd3, 16'h007f);
        add_prog(enc_reg(3'd1, 3'd2, 3'd4, cpu_pkg::fn_add), 0);
        add_wb(3'd4, 16'hffb6);
        add_prog(enc_reg(3'd1, 3'd2, 3'd5, cpu_pkg::fn_sub), 2);
        add_wb(3'd5, 16'h00b4);
        add_prog(enc_reg(3'd2, 3'd3, 3'd6, cpu_pkg::fn_xor), 0);
        add_wb(3'd6, 16'hfffe);
        add_prog(enc_reg(3'd2, 3'd3, 3'd7, cpu_pkg::fn_andn), 0);
        add_wb(3'd7, 16'hff80);
        add_prog(enc_imm(cpu_pkg::op_addi, 3'd4, 3'd4, 5'h1d), 0);
        add_wb(3'd4, 16'hffb3);
        add_prog(enc_imm(cpu_pkg::op_subi, 3'd5, 3'd5, 5'h10), 1);
        add_wb(3'd5, 16'h00c4);
        add_prog(enc_imm(cpu_pkg::op_addi, 3'd3, 3'd3, 5'h0f), 0);
        add_wb(3'd3, 16'h008e);
        // Dependent chain fed back to back.
        add_prog(enc_lbi(3'd1, 8'h01), 0);
        add_wb(3'd1, 16'h0001);
        add_prog(enc_reg(3'd1, 3'd1, 3'd1, cpu_pkg::fn_add), 0);
        add_wb(3'd1, 16'h0002);
        add_prog(enc_reg(3'd1, 3'd1, 3'd1, cpu_pkg::fn_add), 0);
        add_wb(3'd1, 16'h0004);
        add_prog(enc_imm(cpu_pkg::op_subi, 3'd1, 3'd2, 5'h05), 0);
        add_wb(3'd2, 16'hffff);
        add_prog(enc_reg(3'd2, 3'd1, 3'd3, cpu_pkg::fn_xor), 0);
        add_wb(3'd3, 16'hfffb);
        // Store and load through address 0x16.
        add_prog(enc_lbi(3'd6, 8'h12), 1);
        add_wb(3'd6, 16'h0012);
        add_prog(enc_imm(cpu_pkg::op_st, 3'd6, 3'd3, 5'h04), 0);
        add_prog({cpu_pkg::op_nop, 11'b0}, 0);
        add_prog(enc_imm(cpu_pkg::op_ld, 3'd6, 3'd7, 5'h04), 0);
        add_wb(3'd7, 16'hfffb);
        add_prog(enc_reg(3'd7, 3'd4, 3'd0, cpu_pkg::fn_add), 2);
        add_wb(3'd0, 16'hffae);
    endtask

    task close_run();
        int value_errors;
        int other_errors;
        value_errors = wb_value_errors + check_value_errors;
        other_errors = wb_other_errors + check_other_errors;
        $display("Run complete: %0d writebacks, %0d value errors, %0d other errors, %0d timeouts",
                 wb_count, value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task stop_on_timeout(input string what);
        $display("Timeout while %s at %0t", what, $time);
        timeouts++;
        close_run();
    endtask

    // Offers one word and returns once it is sure to be taken on the next rising edge.
    task feed_word(input logic [15:0] word, input int gap, output int stalls);
        int waited;
        stalls = 0;
        for (int g = 0; g < gap; g++) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
        @(negedge clk);
        instr       = word;
        instr_valid = 1'b1;
        #1;
        waited = 0;
        while (instr_ready !== 1'b1 && waited < feed_limit) begin
            stalls++;
            @(negedge clk);
            #1;
            waited++;
        end
        if (instr_ready !== 1'b1) begin
            stop_on_timeout("waiting for the core to accept an instruction");
        end
    endtask

    task run_random(input int count);
        logic [31:0] r;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [1:0]  fn;
        logic [15:0] word;
        logic [15:0] val;
        int          gap;
        int          stalls;
        for (int i = 0; i < count; i++) begin
            r  = lcg_next();
            rd = r[31:29];
            rs = r[28:26];
            rt = r[25:23];
            fn = r[22:21];
            case (r[12:11])
                2'd0: begin
                    word = enc_lbi(rd, r[20:13]);
                    val  = sext8(r[20:13]);
                end
                2'd1: begin
                    word = enc_reg(rs, rt, rd, fn);
                    val  = ref_result(fn, model_regs[rs], model_regs[rt]);
                end
                2'd2: begin
                    word = enc_imm(cpu_pkg::op_addi, rs, rd, r[17:13]);
                    val  = model_regs[rs] + sext5(r[17:13]);
                end
                default: begin
                    word = enc_imm(cpu_pkg::op_subi, rs, rd, r[17:13]);
                    val  = model_regs[rs] - sext5(r[17:13]);
                end
            endcase
            if (r[10]) begin
                gap = 0;
            end else begin
                gap = {30'b0, r[9:8]};
            end
            expect_wb(rd, val);
            feed_word(word, gap, stalls);
        end
    endtask

    // The writeback monitor samples mid-cycle.
    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            wb_count++;
            if (exp_rd >= exp_wr) begin
                wb_other_errors++;
                $display("Unexpected writeback to register %0d at %0t with none pending",
                         wb_reg, $time);
            end else begin
                if (wb_reg !== exp_reg[exp_rd]) begin
                    wb_value_errors++;
                    $display("[ERROR] %0t wb_reg: got %0d, expected %0d",
                             $time, wb_reg, exp_reg[exp_rd]);
                end
                if (wb_data !== exp_val[exp_rd]) begin
                    wb_value_errors++;
                    $display("[ERROR] %0t wb_data: got %h, expected %h",
                             $time, wb_data, exp_val[exp_rd]);
                end
                exp_rd++;
            end
        end
    end

    initial begin
        int stalls;
        int dep_stalls;
        int waited;
        int wb_before;
        rst                = 1'b1;
        instr              = '0;
        instr_valid        = 1'b0;
        lcg_state          = 32'd67547;
        check_value_errors = 0;
        check_other_errors = 0;
        timeouts           = 0;
        exp_wr             = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        load_tables();
        for (int i = 0; i < wb_tab_len; i++) begin
            expect_wb(wb_tab_reg[i], wb_tab_val[i]);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        if (instr_ready !== 1'b1) begin
            check_value_errors++;
            $display("[ERROR] %0t instr_ready: got %b, expected 1", $time, instr_ready);
        end
        if (halted !== 1'b0) begin
            check_value_errors++;
            $display("[ERROR] %0t halted: got %b, expected 0", $time, halted);
        end

        dep_stalls = 0;
        for (int i = 0; i < prog_len; i++) begin
            feed_word(prog_word[i], prog_gap[i], stalls);
            if (i >= dep_first && i <= dep_last) begin
                dep_stalls += stalls;
            end
        end
        if (dep_stalls == 0) begin
            check_other_errors++;
            $display("The core never held off the dependent back-to-back sequence");
        end

        run_random(40);
        @(negedge clk);
        instr_valid = 1'b0;
        waited = 0;
        while (exp_rd < exp_wr && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd < exp_wr) begin
            stop_on_timeout("waiting for the remaining writebacks");
        end

        feed_word({cpu_pkg::op_halt, 11'b0}, 1, stalls);
        @(negedge clk);
        // A word offered after HALT must never be taken.
        instr       = enc_lbi(3'd1, 8'h55);
        instr_valid = 1'b1;
        waited = 0;
        while (halted !== 1'b1 && waited < halt_limit) begin
            @(negedge clk);
            waited++;
        end
        if (halted !== 1'b1) begin
            stop_on_timeout("waiting for halted to rise");
        end
        wb_before = wb_count;
        repeat (20) begin
            @(negedge clk);
            #1;
            if (instr_ready !== 1'b0) begin
                check_value_errors++;
                $display("[ERROR] %0t instr_ready: got %b, expected 0", $time, instr_ready);
            end
            if (halted !== 1'b1) begin
                check_value_errors++;
                $display("[ERROR] %0t halted: got %b, expected 1", $time, halted);
            end
        end
        if (wb_count != wb_before) begin
            check_other_errors++;
            $display("Writebacks kept appearing after the core halted");
        end
        close_run();
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::op_w-1:0]   alu_op,
    input  logic [1:0]                 funct,
    input  logic [cpu_pkg::data_w-1:0] a,
    input  logic [cpu_pkg::data_w-1:0] b,
    output logic [cpu_pkg::data_w-1:0] result
);

    logic [cpu_pkg::data_w-1:0] reg_result;

    // The function field selects the register format operation.
    always_comb begin
        case (funct)
            cpu_pkg::fn_add:  reg_result = a + b;
            cpu_pkg::fn_sub:  reg_result = a - b;
            cpu_pkg::fn_xor:  reg_result = a ^ b;
            cpu_pkg::fn_andn: reg_result = a & ~b;
            default:          reg_result = '0;
        endcase
    end

    // Loads and stores arrive here as alu_add for base plus offset.
    always_comb begin
        case (alu_op)
            cpu_pkg::alu_reg:    result = reg_result;
            cpu_pkg::alu_add:    result = a + b;
            cpu_pkg::alu_sub:    result = a - b;
            cpu_pkg::alu_xor:    result = a ^ b;
            cpu_pkg::alu_andn:   result = a & ~b;
            cpu_pkg::alu_pass_b: result = b;
            default:             result = '0;
        endcase
    end

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter int dmem_depth = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [cpu_pkg::data_w-1:0] instr,
    input  logic                       instr_valid,
    output logic                       instr_ready,
    output logic                       wb_valid,
    output logic [cpu_pkg::reg_w-1:0]  wb_reg,
    output logic [cpu_pkg::data_w-1:0] wb_data,
    output logic                       halted
);

    logic [cpu_pkg::reg_w-1:0]  dec_rs, dec_rt, dec_rd;
    logic                       dec_rs_used, dec_rt_used;
    logic [cpu_pkg::data_w-1:0] dec_imm;
    logic [cpu_pkg::op_w-1:0]   dec_alu_op;
    logic [1:0]                 dec_funct;
    logic                       dec_alu_src, dec_mem_read, dec_mem_write;
    logic                       dec_mem_to_reg, dec_reg_write, dec_halt;

    logic [cpu_pkg::data_w-1:0] read1, read2;
    logic                       stall, accept, control_zero, halt_seen;

    logic [cpu_pkg::data_w-1:0] ex_read1, ex_read2, ex_imm, ex_b, ex_result;
    logic [cpu_pkg::op_w-1:0]   ex_alu_op;
    logic [1:0]                 ex_funct;
    logic [cpu_pkg::reg_w-1:0]  ex_rd;
    logic                       ex_alu_src, ex_mem_read, ex_mem_write;
    logic                       ex_mem_to_reg, ex_reg_write, ex_halt;

    // Copy of the EX/MEM destination for the hazard check.
    logic [cpu_pkg::reg_w-1:0]  mem_rd;
    logic                       mem_reg_write;

    assign instr_ready  = !stall && !halt_seen;
    assign accept       = instr_valid && instr_ready;
    assign control_zero = !accept;
    assign ex_b         = ex_alu_src ? ex_imm : ex_read2;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_seen     <= 1'b0;
            mem_reg_write <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write;
            if (accept && dec_halt) begin
                halt_seen <= 1'b1;
            end
        end
        mem_rd <= ex_rd;
    end

    decoder u_decoder (
        .instr(instr), .rs(dec_rs), .rt(dec_rt), .rd(dec_rd),
        .rs_used(dec_rs_used), .rt_used(dec_rt_used), .imm(dec_imm),
        .alu_op(dec_alu_op), .funct(dec_funct), .alu_src(dec_alu_src),
        .mem_read(dec_mem_read), .mem_write(dec_mem_write), .mem_to_reg(dec_mem_to_reg),
        .reg_write(dec_reg_write), .halt(dec_halt)
    );

    regfile u_regfile (
        .clk(clk), .rst(rst), .rd_addr1(dec_rs), .rd_addr2(dec_rt),
        .rd_data1(read1), .rd_data2(read2),
        .wr_en(wb_valid), .wr_addr(wb_reg), .wr_data(wb_data)
    );

    hazard_unit u_hazard (
        .instr_valid(instr_valid), .rs(dec_rs), .rt(dec_rt),
        .rs_used(dec_rs_used), .rt_used(dec_rt_used),
        .ex_rd(ex_rd), .ex_reg_write(ex_reg_write),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .stall(stall)
    );

    idex_reg u_idex (
        .clk(clk), .rst(rst), .control_zero(control_zero),
        .read1_in(read1), .read2_in(read2), .imm_in(dec_imm),
        .alu_op_in(dec_alu_op), .funct_in(dec_funct), .write_reg_in(dec_rd),
        .alu_src_in(dec_alu_src), .mem_read_in(dec_mem_read),
        .mem_write_in(dec_mem_write), .mem_to_reg_in(dec_mem_to_reg),
        .reg_write_in(dec_reg_write), .halt_in(dec_halt),
        .read1_out(ex_read1), .read2_out(ex_read2), .imm_out(ex_imm),
        .alu_op_out(ex_alu_op), .funct_out(ex_funct), .write_reg_out(ex_rd),
        .alu_src_out(ex_alu_src), .mem_read_out(ex_mem_read),
        .mem_write_out(ex_mem_write), .mem_to_reg_out(ex_mem_to_reg),
        .reg_write_out(ex_reg_write), .halt_out(ex_halt)
    );

    alu u_alu (
        .alu_op(ex_alu_op), .funct(ex_funct), .a(ex_read1), .b(ex_b), .result(ex_result)
    );

    mem_stage #(.dmem_depth(dmem_depth)) u_mem (
        .clk(clk), .rst(rst), .alu_result(ex_result), .store_data(ex_read2),
        .write_reg(ex_rd), .mem_read(ex_mem_read), .mem_write(ex_mem_write),
        .mem_to_reg(ex_mem_to_reg), .reg_write(ex_reg_write), .halt(ex_halt),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
    );

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

    // Data path and instruction word width.
    localparam int data_w = 16;

    // Register index width for the eight-entry register file.
    localparam int reg_w = 3;

    // Width of the ALU operation code carried through ID/EX.
    localparam int op_w = 5;

    // Primary opcodes sit in instruction bits 15 to 11.
    localparam logic [4:0] op_nop  = 5'b00000;
    localparam logic [4:0] op_halt = 5'b00001;
    localparam logic [4:0] op_alu  = 5'b11011;
    localparam logic [4:0] op_addi = 5'b01000;
    localparam logic [4:0] op_subi = 5'b01001;
    localparam logic [4:0] op_lbi  = 5'b11000;
    localparam logic [4:0] op_ld   = 5'b10001;
    localparam logic [4:0] op_st   = 5'b10000;

    // The function field of the register format sits in bits 1 to 0.
    localparam logic [1:0] fn_add  = 2'b00;
    localparam logic [1:0] fn_sub  = 2'b01;
    localparam logic [1:0] fn_xor  = 2'b10;
    localparam logic [1:0] fn_andn = 2'b11;

    // ALU operation codes produced by the decoder.
    localparam logic [op_w-1:0] alu_add    = 5'd0;
    localparam logic [op_w-1:0] alu_sub    = 5'd1;
    localparam logic [op_w-1:0] alu_xor    = 5'd2;
    localparam logic [op_w-1:0] alu_andn   = 5'd3;
    localparam logic [op_w-1:0] alu_pass_b = 5'd4;

    // The register format takes its ALU operation from the function field.
    localparam logic [op_w-1:0] alu_reg    = 5'd5;

endpackage

/* hw/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic [cpu_pkg::data_w-1:0] instr,
    output logic [cpu_pkg::reg_w-1:0]  rs,
    output logic [cpu_pkg::reg_w-1:0]  rt,
    output logic [cpu_pkg::reg_w-1:0]  rd,
    output logic                       rs_used,
    output logic                       rt_used,
    output logic [cpu_pkg::data_w-1:0] imm,
    output logic [cpu_pkg::op_w-1:0]   alu_op,
    output logic [1:0]                 funct,
    output logic                       alu_src,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic                       mem_to_reg,
    output logic                       reg_write,
    output logic                       halt
);

    logic [4:0]                 opcode;
    logic [cpu_pkg::data_w-1:0] imm5;
    logic [cpu_pkg::data_w-1:0] imm8;

    assign opcode = instr[15:11];
    assign imm5   = {{(cpu_pkg::data_w-5){instr[4]}}, instr[4:0]};
    assign imm8   = {{(cpu_pkg::data_w-8){instr[7]}}, instr[7:0]};

    // Source fields sit in the same place for every format that reads registers.
    assign rs    = instr[10:8];
    assign rt    = instr[7:5];
    assign funct = instr[1:0];

    always_comb begin
        rd         = instr[7:5];
        rs_used    = 1'b0;
        rt_used    = 1'b0;
        imm        = '0;
        alu_op     = cpu_pkg::alu_add;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        halt       = 1'b0;
        case (opcode)
            cpu_pkg::op_alu: begin
                rd        = instr[4:2];
                rs_used   = 1'b1;
                rt_used   = 1'b1;
                alu_op    = cpu_pkg::alu_reg;
                reg_write = 1'b1;
            end
            cpu_pkg::op_addi, cpu_pkg::op_subi: begin
                rs_used   = 1'b1;
                imm       = imm5;
                alu_op    = (opcode == cpu_pkg::op_subi) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::op_lbi: begin
                rd        = instr[10:8];
                imm       = imm8;
                alu_op    = cpu_pkg::alu_pass_b;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::op_ld: begin
                rs_used    = 1'b1;
                imm        = imm5;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            cpu_pkg::op_st: begin
                // Store data comes from the register in bits 7 to 5.
                rs_used   = 1'b1;
                rt_used   = 1'b1;
                imm       = imm5;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            cpu_pkg::op_halt: begin
                halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic                      instr_valid,
    input  logic [cpu_pkg::reg_w-1:0] rs,
    input  logic [cpu_pkg::reg_w-1:0] rt,
    input  logic                      rs_used,
    input  logic                      rt_used,
    input  logic [cpu_pkg::reg_w-1:0] ex_rd,
    input  logic                      ex_reg_write,
    input  logic [cpu_pkg::reg_w-1:0] mem_rd,
    input  logic                      mem_reg_write,
    output logic                      stall
);

    logic rs_conflict;
    logic rt_conflict;

    // Only the writers in ID/EX and EX/MEM matter; MEM/WB goes through
    // the register file bypass.
    assign rs_conflict = rs_used &&
                         ((ex_reg_write && ex_rd == rs) || (mem_reg_write && mem_rd == rs));

    assign rt_conflict = rt_used &&
                         ((ex_reg_write && ex_rd == rt) || (mem_reg_write && mem_rd == rt));

    assign stall = instr_valid && (rs_conflict || rt_conflict);

endmodule

/* hw/idex_reg.sv */
`timescale 1ns/1ps

module idex_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       control_zero,
    input  logic [cpu_pkg::data_w-1:0] read1_in,
    input  logic [cpu_pkg::data_w-1:0] read2_in,
    input  logic [cpu_pkg::data_w-1:0] imm_in,
    input  logic [cpu_pkg::op_w-1:0]   alu_op_in,
    input  logic [1:0]                 funct_in,
    input  logic [cpu_pkg::reg_w-1:0]  write_reg_in,
    input  logic                       alu_src_in,
    input  logic                       mem_read_in,
    input  logic                       mem_write_in,
    input  logic                       mem_to_reg_in,
    input  logic                       reg_write_in,
    input  logic                       halt_in,
    output logic [cpu_pkg::data_w-1:0] read1_out,
    output logic [cpu_pkg::data_w-1:0] read2_out,
    output logic [cpu_pkg::data_w-1:0] imm_out,
    output logic [cpu_pkg::op_w-1:0]   alu_op_out,
    output logic [1:0]                 funct_out,
    output logic [cpu_pkg::reg_w-1:0]  write_reg_out,
    output logic                       alu_src_out,
    output logic                       mem_read_out,
    output logic                       mem_write_out,
    output logic                       mem_to_reg_out,
    output logic                       reg_write_out,
    output logic                       halt_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            read1_out      <= '0;
            read2_out      <= '0;
            imm_out        <= '0;
            alu_op_out     <= '0;
            funct_out      <= '0;
            write_reg_out  <= '0;
            alu_src_out    <= 1'b0;
            mem_read_out   <= 1'b0;
            mem_write_out  <= 1'b0;
            mem_to_reg_out <= 1'b0;
            reg_write_out  <= 1'b0;
            halt_out       <= 1'b0;
        end else begin
            read1_out      <= read1_in;
            read2_out      <= read2_in;
            imm_out        <= imm_in;
            alu_op_out     <= alu_op_in;
            funct_out      <= funct_in;
            write_reg_out  <= write_reg_in;
            alu_src_out    <= alu_src_in;
            mem_read_out   <= mem_read_in;
            mem_to_reg_out <= mem_to_reg_in;
            // A stalled or empty cycle enters as a bubble with no side effects.
            mem_write_out  <= control_zero ? 1'b0 : mem_write_in;
            reg_write_out  <= control_zero ? 1'b0 : reg_write_in;
            halt_out       <= control_zero ? 1'b0 : halt_in;
        end
    end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int dmem_depth = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [cpu_pkg::data_w-1:0] alu_result,
    input  logic [cpu_pkg::data_w-1:0] store_data,
    input  logic [cpu_pkg::reg_w-1:0]  write_reg,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  logic                       mem_to_reg,
    input  logic                       reg_write,
    input  logic                       halt,
    output logic                       wb_valid,
    output logic [cpu_pkg::reg_w-1:0]  wb_reg,
    output logic [cpu_pkg::data_w-1:0] wb_data,
    output logic                       halted
);

    localparam int addr_w = $clog2(dmem_depth);

    logic [cpu_pkg::data_w-1:0] exmem_alu;
    logic [cpu_pkg::data_w-1:0] exmem_store;
    logic [cpu_pkg::reg_w-1:0]  exmem_reg;
    logic                       exmem_mem_read;
    logic                       exmem_mem_write;
    logic                       exmem_mem_to_reg;
    logic                       exmem_reg_write;
    logic                       exmem_halt;

    logic [cpu_pkg::data_w-1:0] dmem [dmem_depth];
    logic [addr_w-1:0]          dmem_idx;
    logic [cpu_pkg::data_w-1:0] load_data;

    always_ff @(posedge clk) begin
        exmem_alu   <= alu_result;
        exmem_store <= store_data;
        exmem_reg   <= write_reg;
        if (rst) begin
            exmem_mem_read   <= 1'b0;
            exmem_mem_write  <= 1'b0;
            exmem_mem_to_reg <= 1'b0;
            exmem_reg_write  <= 1'b0;
            exmem_halt       <= 1'b0;
        end else begin
            exmem_mem_read   <= mem_read;
            exmem_mem_write  <= mem_write;
            exmem_mem_to_reg <= mem_to_reg;
            exmem_reg_write  <= reg_write;
            exmem_halt       <= halt;
        end
    end

    // Only the low address bits select a word.
    assign dmem_idx  = exmem_alu[addr_w-1:0];
    assign load_data = exmem_mem_read ? dmem[dmem_idx] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (exmem_mem_write) begin
            dmem[dmem_idx] <= exmem_store;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= exmem_reg;
        wb_data <= exmem_mem_to_reg ? load_data : exmem_alu;
        if (rst) begin
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= exmem_reg_write;
            // Once a HALT reaches writeback the core stays halted.
            if (exmem_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [cpu_pkg::reg_w-1:0]  rd_addr1,
    input  logic [cpu_pkg::reg_w-1:0]  rd_addr2,
    output logic [cpu_pkg::data_w-1:0] rd_data1,
    output logic [cpu_pkg::data_w-1:0] rd_data2,
    input  logic                       wr_en,
    input  logic [cpu_pkg::reg_w-1:0]  wr_addr,
    input  logic [cpu_pkg::data_w-1:0] wr_data
);

    localparam int num_regs = 1 << cpu_pkg::reg_w;

    logic [cpu_pkg::data_w-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // A write in this cycle is visible to a read of the same register,
    // so the writeback stage never needs a stall.
    assign rd_data1 = (wr_en && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
    assign rd_data2 = (wr_en && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -f src.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_core > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation did not finish cleanly"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* src.f */
hw/cpu_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/idex_reg.sv
hw/alu.sv
hw/mem_stage.sv
hw/core_top.sv
bench/tb_core.sv
